/* hw/bpb_addr_pkg.sv */
`default_nettype none

package bpb_addr_pkg;

    localparam int WORD_WIDTH = 32;

    // entry select bits sit just above the byte offset
    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH = 4;
    localparam int ENTRY_COUNT = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH = WORD_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;

    typedef logic [WORD_WIDTH - 1:0] word_t;
    typedef logic [INDEX_WIDTH - 1:0] index_t;
    typedef logic [TAG_WIDTH - 1:0] tag_t;

    // one write enable per entry
    typedef logic [ENTRY_COUNT - 1:0] entry_mask_t;

    // boot vector
    localparam word_t RESET_TARGET = 32'hbfc0_0000;

endpackage

`default_nettype wire

/* hw/bpb_counter_pkg.sv */
`default_nettype none

package bpb_counter_pkg;

    // two-bit taken counter
    //   cold    -> warm on taken
    //   warm    -> hot on taken, cold on not-taken
    //   hot     -> cooling on not-taken
    //   cooling -> hot on taken, cold on not-taken
    // upper bit is the prediction
    typedef enum logic [1:0]
    {
        cnt_cold    = 2'b00,
        cnt_warm    = 2'b01,
        cnt_hot     = 2'b11,
        cnt_cooling = 2'b10
    } counter_t;

endpackage

`default_nettype wire

/* hw/bpb_commit_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module bpb_commit_stage
(
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      stall,
    input  wire logic                      commit_valid,
    input  wire bpb_addr_pkg::word_t       commit_pc,
    input  wire logic                      commit_taken,
    input  wire bpb_addr_pkg::word_t       commit_target,
    output bpb_addr_pkg::entry_mask_t      entry_wen,
    output bpb_addr_pkg::tag_t             wr_tag,
    output logic                           wr_taken,
    output bpb_addr_pkg::word_t            wr_target
);

    logic                  held_valid;
    bpb_addr_pkg::index_t  held_index;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            held_valid <= 1'b0;
        end
        else if (!stall)
        begin
            held_valid <= commit_valid;
        end
    end

    // commit payload
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            wr_tag     <= commit_pc[bpb_addr_pkg::WORD_WIDTH - 1 -: bpb_addr_pkg::TAG_WIDTH];
            held_index <= commit_pc[bpb_addr_pkg::OFFSET_WIDTH +: bpb_addr_pkg::INDEX_WIDTH];
            wr_taken   <= commit_taken;
            wr_target  <= commit_target;
        end
    end

    // one-hot decode gated by stall
    always_comb
    begin
        for (int i = 0; i < bpb_addr_pkg::ENTRY_COUNT; i++)
        begin
            entry_wen[i] = held_valid && !stall
                && (held_index == bpb_addr_pkg::index_t'(i));
        end
    end

endmodule

`default_nettype wire

/* hw/bpb_entry.sv */
`timescale 1ns/1ns
`default_nettype none

module bpb_entry
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  wen,
    input  wire bpb_addr_pkg::tag_t    wr_tag,
    input  wire logic                  wr_taken,
    input  wire bpb_addr_pkg::word_t   wr_target,
    output bpb_addr_pkg::tag_t         tag,
    output logic                       taken,
    output bpb_addr_pkg::word_t        target
);

    bpb_counter_pkg::counter_t state;
    bpb_counter_pkg::counter_t state_next;

    // counter step on a tag match
    always_comb
    begin
        case (state)
            bpb_counter_pkg::cnt_cold:
            begin
                state_next = wr_taken ? bpb_counter_pkg::cnt_warm : bpb_counter_pkg::cnt_cold;
            end
            bpb_counter_pkg::cnt_warm:
            begin
                state_next = wr_taken ? bpb_counter_pkg::cnt_hot : bpb_counter_pkg::cnt_cold;
            end
            bpb_counter_pkg::cnt_hot:
            begin
                state_next = wr_taken ? bpb_counter_pkg::cnt_hot : bpb_counter_pkg::cnt_cooling;
            end
            bpb_counter_pkg::cnt_cooling:
            begin
                state_next = wr_taken ? bpb_counter_pkg::cnt_hot : bpb_counter_pkg::cnt_cold;
            end
            default:
            begin
                state_next = bpb_counter_pkg::cnt_cold;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tag    <= '0;
            state  <= bpb_counter_pkg::cnt_cold;
            target <= bpb_addr_pkg::RESET_TARGET;
        end
        else if (wen)
        begin
            if (wr_tag != tag)
            begin
                // new branch takes over the line
                tag    <= wr_tag;
                state  <= bpb_counter_pkg::cnt_cold;
                target <= wr_target;
            end
            else
            begin
                state <= state_next;
            end
        end
    end

    assign taken = state[1];

endmodule

`default_nettype wire

/* hw/bpb_lookup_select.sv */
`timescale 1ns/1ns
`default_nettype none

module bpb_lookup_select
(
    input  wire bpb_addr_pkg::word_t [1:0]                             lookup_pc,
    input  wire bpb_addr_pkg::tag_t [bpb_addr_pkg::ENTRY_COUNT - 1:0]  entry_tag,
    input  wire bpb_addr_pkg::entry_mask_t                             entry_taken,
    input  wire bpb_addr_pkg::word_t [bpb_addr_pkg::ENTRY_COUNT - 1:0] entry_target,
    output logic [1:0]                                                 lookup_hit,
    output logic [1:0]                                                 lookup_taken,
    output bpb_addr_pkg::word_t [1:0]                                  lookup_target
);

    // one read port per fetch slot
    for (genvar s = 0; s < 2; s++)
    begin : g_slot
        bpb_addr_pkg::index_t slot_index;
        bpb_addr_pkg::tag_t   slot_tag;

        assign slot_index =
            lookup_pc[s][bpb_addr_pkg::OFFSET_WIDTH +: bpb_addr_pkg::INDEX_WIDTH];
        assign slot_tag =
            lookup_pc[s][bpb_addr_pkg::WORD_WIDTH - 1 -: bpb_addr_pkg::TAG_WIDTH];

        assign lookup_hit[s] = (entry_tag[slot_index] == slot_tag);

        // a miss never predicts taken
        assign lookup_taken[s] = lookup_hit[s] && entry_taken[slot_index];

        assign lookup_target[s] = entry_target[slot_index];
    end

endmodule

`default_nettype wire

/* hw/bpb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bpb_top
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       stall,
    input  wire bpb_addr_pkg::word_t [1:0]  lookup_pc,
    input  wire logic                       commit_valid,
    input  wire bpb_addr_pkg::word_t        commit_pc,
    input  wire logic                       commit_taken,
    input  wire bpb_addr_pkg::word_t        commit_target,
    output logic [1:0]                      lookup_hit,
    output logic [1:0]                      lookup_taken,
    output bpb_addr_pkg::word_t [1:0]       lookup_target
);

    bpb_addr_pkg::entry_mask_t                             entry_wen;
    bpb_addr_pkg::tag_t                                    wr_tag;
    logic                                                  wr_taken;
    bpb_addr_pkg::word_t                                   wr_target;

    bpb_addr_pkg::tag_t [bpb_addr_pkg::ENTRY_COUNT - 1:0]  entry_tag;
    bpb_addr_pkg::entry_mask_t                             entry_taken;
    bpb_addr_pkg::word_t [bpb_addr_pkg::ENTRY_COUNT - 1:0] entry_target;

    bpb_commit_stage u_commit
    (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_taken  (commit_taken),
        .commit_target (commit_target),
        .entry_wen     (entry_wen),
        .wr_tag        (wr_tag),
        .wr_taken      (wr_taken),
        .wr_target     (wr_target)
    );

    // write data is shared and only wen differs per line
    for (genvar i = 0; i < bpb_addr_pkg::ENTRY_COUNT; i++)
    begin : g_entry
        bpb_entry u_entry
        (
            .clk       (clk),
            .reset     (reset),
            .wen       (entry_wen[i]),
            .wr_tag    (wr_tag),
            .wr_taken  (wr_taken),
            .wr_target (wr_target),
            .tag       (entry_tag[i]),
            .taken     (entry_taken[i]),
            .target    (entry_target[i])
        );
    end

    bpb_lookup_select u_select
    (
        .lookup_pc     (lookup_pc),
        .entry_tag     (entry_tag),
        .entry_taken   (entry_taken),
        .entry_target  (entry_target),
        .lookup_hit    (lookup_hit),
        .lookup_taken  (lookup_taken),
        .lookup_target (lookup_target)
    );

endmodule

`default_nettype wire

/* tests/bpb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module bpb_checker
(
    input wire logic                       clk,
    input wire logic                       reset,
    input wire logic                       stall,
    input wire bpb_addr_pkg::entry_mask_t  entry_wen,
    input wire logic [1:0]                 lookup_hit,
    input wire logic [1:0]                 lookup_taken
);

    // at most one entry written per cycle
    wen_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(entry_wen))
        else $error("entry_wen has more than one bit set");

    wen_stalled: assert property (@(posedge clk) disable iff (reset)
        stall |-> entry_wen == '0)
        else $error("an entry was written while stall was high");

    // a miss never predicts taken
    taken_needs_hit: assert property (@(posedge clk) disable iff (reset)
        (lookup_taken & ~lookup_hit) == 2'b00)
        else $error("lookup_taken set without lookup_hit");

endmodule

`default_nettype wire

/* tests/bpb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bpb_tb;

    localparam int RESET_CYCLES = 3;
    localparam int RESET_TEST_CYCLES = 16;
    localparam int ALLOC_TEST_CYCLES = 4;
    localparam int TRAIN_TEST_CYCLES = 24;
    localparam int STALL_TEST_CYCLES = 11;
    localparam int RANDOM_CYCLES = 2000;
    localparam int MARGIN_CYCLES = 200;
    localparam int TOTAL_CYCLES = RESET_CYCLES + RESET_TEST_CYCLES + ALLOC_TEST_CYCLES
        + TRAIN_TEST_CYCLES + STALL_TEST_CYCLES + RANDOM_CYCLES;

    // directed addresses, each a tag, an index and a zero byte offset
    localparam bpb_addr_pkg::word_t ALLOC_PC = {26'h1abcdef, 4'h5, 2'b00};
    localparam bpb_addr_pkg::word_t ALIAS_PC = {26'h2000001, 4'h5, 2'b00};
    localparam bpb_addr_pkg::word_t TRAIN_PC = {26'h0000777, 4'h9, 2'b00};
    localparam bpb_addr_pkg::word_t STALL_PC = {26'h0000abc, 4'h3, 2'b00};

    // taken, taken, not-taken, taken, not-taken, not-taken from bit 0 up
    localparam logic [5:0] TRAIN_DIR = 6'b001011;
    localparam logic [5:0] TRAIN_EXP = 6'b011110;

    logic                       clk;
    logic                       reset;
    logic                       stall;
    bpb_addr_pkg::word_t [1:0]  lookup_pc;
    logic                       commit_valid;
    bpb_addr_pkg::word_t        commit_pc;
    logic                       commit_taken;
    bpb_addr_pkg::word_t        commit_target;
    logic [1:0]                 lookup_hit;
    logic [1:0]                 lookup_taken;
    bpb_addr_pkg::word_t [1:0]  lookup_target;

    integer seed;

    // reference model of the entries and the commit register
    bpb_addr_pkg::tag_t    m_tag [bpb_addr_pkg::ENTRY_COUNT];
    logic [1:0]            m_count [bpb_addr_pkg::ENTRY_COUNT];
    bpb_addr_pkg::word_t   m_target [bpb_addr_pkg::ENTRY_COUNT];
    logic                  p_valid;
    bpb_addr_pkg::tag_t    p_tag;
    bpb_addr_pkg::index_t  p_index;
    logic                  p_taken;
    bpb_addr_pkg::word_t   p_target;

    bpb_top dut
    (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .lookup_pc     (lookup_pc),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_taken  (commit_taken),
        .commit_target (commit_target),
        .lookup_hit    (lookup_hit),
        .lookup_taken  (lookup_taken),
        .lookup_target (lookup_target)
    );

    bind bpb_top bpb_checker u_checker
    (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .entry_wen    (entry_wen),
        .lookup_hit   (lookup_hit),
        .lookup_taken (lookup_taken)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic bpb_addr_pkg::tag_t tag_of(input bpb_addr_pkg::word_t pc);
        return pc[31:6];
    endfunction

    function automatic bpb_addr_pkg::index_t index_of(input bpb_addr_pkg::word_t pc);
        return pc[5:2];
    endfunction

    function automatic logic [1:0] count_step(input logic [1:0] c, input logic t);
        case (c)
            2'b00: count_step = t ? 2'b01 : 2'b00;
            2'b01: count_step = t ? 2'b11 : 2'b00;
            2'b11: count_step = t ? 2'b11 : 2'b10;
            default: count_step = t ? 2'b11 : 2'b00;
        endcase
    endfunction

    function automatic bpb_addr_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    // four tags including tag zero so aliasing is common
    function automatic bpb_addr_pkg::word_t random_pc();
        bpb_addr_pkg::word_t r;
        r = $random(seed);
        return {24'h0, r[9:8], r[5:0]};
    endfunction

    task automatic model_reset();
        for (int i = 0; i < bpb_addr_pkg::ENTRY_COUNT; i++)
        begin
            m_tag[i] = '0;
            m_count[i] = 2'b00;
            m_target[i] = bpb_addr_pkg::RESET_TARGET;
        end
        p_valid = 1'b0;
    endtask

    task automatic model_edge();
        if (reset)
        begin
            model_reset();
        end
        else if (!stall)
        begin
            if (p_valid && m_tag[p_index] != p_tag)
            begin
                m_tag[p_index] = p_tag;
                m_count[p_index] = 2'b00;
                m_target[p_index] = p_target;
            end
            else if (p_valid)
            begin
                m_count[p_index] = count_step(m_count[p_index], p_taken);
            end
            p_valid = commit_valid;
            p_tag = tag_of(commit_pc);
            p_index = index_of(commit_pc);
            p_taken = commit_taken;
            p_target = commit_target;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic check_lookup(input string name);
        bpb_addr_pkg::index_t idx;
        logic hit;
        #4;
        for (int s = 0; s < 2; s++)
        begin
            idx = index_of(lookup_pc[s]);
            hit = (m_tag[idx] == tag_of(lookup_pc[s]));
            check_value($sformatf("%s slot%0d hit", name, s), 32'(hit), 32'(lookup_hit[s]));
            check_value($sformatf("%s slot%0d taken", name, s),
                        32'(hit && m_count[idx][1]), 32'(lookup_taken[s]));
            check_value($sformatf("%s slot%0d target", name, s),
                        m_target[idx], lookup_target[s]);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        model_edge();
        #1;
    endtask

    task automatic run_cycle(input string name, input logic stall_in, input logic valid_in,
                             input bpb_addr_pkg::word_t pc_in, input logic taken_in,
                             input bpb_addr_pkg::word_t target_in,
                             input bpb_addr_pkg::word_t look0,
                             input bpb_addr_pkg::word_t look1);
        next_edge();
        stall = stall_in;
        commit_valid = valid_in;
        commit_pc = pc_in;
        commit_taken = taken_in;
        commit_target = target_in;
        lookup_pc[0] = look0;
        lookup_pc[1] = look1;
        check_lookup(name);
    endtask

    // one commit and two idle cycles until it shows up in lookup
    task automatic commit_and_settle(input string name, input bpb_addr_pkg::word_t pc,
                                     input logic taken, input bpb_addr_pkg::word_t target);
        run_cycle(name, 1'b0, 1'b1, pc, taken, target, pc, rand_word());
        repeat (2)
        begin
            run_cycle(name, 1'b0, 1'b0, rand_word(), 1'b1, rand_word(), pc, rand_word());
        end
    endtask

    initial
    begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * 10);
        $display("timeout: the tests did not finish within %0d cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        bpb_addr_pkg::word_t r;
        seed = 62104;
        reset = 1'b1;
        stall = 1'b0;
        commit_valid = 1'b0;
        commit_pc = '0;
        commit_taken = 1'b0;
        commit_target = '0;
        lookup_pc = '0;
        model_reset();
        repeat (RESET_CYCLES) next_edge();
        reset = 1'b0;

        // slot 0 stays in the zero tag while slot 1 roams
        for (int i = 0; i < RESET_TEST_CYCLES; i++)
        begin
            r = rand_word();
            run_cycle("reset state", 1'b0, 1'b0, '0, 1'b0, '0, {26'h0, r[5:0]}, rand_word());
            check_value("reset state zero tag hit", 32'd1, 32'(lookup_hit[0]));
        end

        commit_and_settle("allocation", ALLOC_PC, 1'b1, 32'h0040_1000);
        check_value("allocation hit", 32'd1, 32'(lookup_hit[0]));
        check_value("allocation taken", 32'd0, 32'(lookup_taken[0]));
        check_value("allocation target", 32'h0040_1000, lookup_target[0]);
        run_cycle("alias miss", 1'b0, 1'b0, '0, 1'b0, '0, ALIAS_PC, rand_word());
        check_value("alias miss hit", 32'd0, 32'(lookup_hit[0]));

        commit_and_settle("training alloc", TRAIN_PC, 1'b0, 32'h0040_2000);
        for (int i = 0; i < 6; i++)
        begin
            commit_and_settle("training", TRAIN_PC, TRAIN_DIR[i], 32'h0040_2000);
            check_value($sformatf("training step %0d taken", i),
                        32'(TRAIN_EXP[i]), 32'(lookup_taken[0]));
        end
        commit_and_settle("training retarget", TRAIN_PC, 1'b1, 32'h0040_3000);
        check_value("training target kept", 32'h0040_2000, lookup_target[0]);

        // commits offered under stall are dropped
        repeat (3)
        begin
            run_cycle("stall drop", 1'b1, 1'b1, STALL_PC, 1'b1, 32'h0040_4000, STALL_PC,
                      rand_word());
        end
        repeat (2)
        begin
            run_cycle("stall drop", 1'b0, 1'b0, '0, 1'b0, '0, STALL_PC, rand_word());
        end
        check_value("stall drop hit", 32'd0, 32'(lookup_hit[0]));

        // captured commit waits out the stall
        run_cycle("stall hold", 1'b0, 1'b1, STALL_PC, 1'b1, 32'h0040_4000, STALL_PC, '0);
        repeat (3)
        begin
            run_cycle("stall hold", 1'b1, 1'b0, '0, 1'b0, '0, STALL_PC, rand_word());
            check_value("stall hold hit", 32'd0, 32'(lookup_hit[0]));
        end
        run_cycle("stall release", 1'b0, 1'b0, '0, 1'b0, '0, STALL_PC, rand_word());
        check_value("stall release hit", 32'd0, 32'(lookup_hit[0]));
        run_cycle("stall release", 1'b0, 1'b0, '0, 1'b0, '0, STALL_PC, rand_word());
        check_value("stall release hit", 32'd1, 32'(lookup_hit[0]));
        check_value("stall release target", 32'h0040_4000, lookup_target[0]);

        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            r = rand_word();
            run_cycle("random traffic", r[2:0] == 3'b000, r[4] | r[5], random_pc(), r[6],
                      rand_word(), random_pc(), random_pc());
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/bpb_addr_pkg.sv
hw/bpb_counter_pkg.sv
hw/bpb_commit_stage.sv
hw/bpb_entry.sv
hw/bpb_lookup_select.sv
hw/bpb_top.sv
tests/bpb_checker.sv
tests/bpb_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bpb_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line appears in the output
run: build
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
